//--- vlog.f
+incdir+include
verilog/rob_pkg.sv
verilog/rob_entry.sv
verilog/rob.sv
verilog/rename_map.sv
verilog/rob_top.sv
tb/tb_rob_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ROB testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

verilator --binary --assert -Wno-fatal --top-module tb_rob_top -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_rob_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

echo "$sim_out" | grep -q "^sim passed$"
if [ $? -ne 0 ]; then
   exit 1
fi
exit 0

//--- tb/rob_input.txt
// cmd (0 idle, 1 dispatch, 2 complete) f0 f1 f2 f3 f4, then expected:
// disp_robid src_dep1 src_dep0 retire_valid robid pdst pdst_old flush_valid flush_tgt
1 1 1 0 2 3 0 00 00 0 0 0 0 0 00000000 // dispatch: has_dst dst is_branch src1 src0
1 1 2 0 1 0 1 10 00 0 0 0 0 0 00000000
1 1 1 0 1 2 2 10 11 0 0 0 0 0 00000000
1 1 3 1 1 3 3 12 00 0 0 0 0 0 00000000 // branch
1 1 4 0 3 2 4 13 11 0 0 0 0 0 00000000
1 1 2 0 4 1 5 14 12 0 0 0 0 0 00000000
1 1 5 0 2 0 6 15 00 0 0 0 0 0 00000000
1 1 6 0 5 7 7 16 00 0 0 0 0 0 00000000 // ROB now full
2 2 0 00000000 0 0 0 00 00 0 0 0 0 0 00000000 // complete: robid mispred tgt
2 0 0 00000000 0 0 0 00 00 0 0 0 0 0 00000000
2 1 0 00000000 0 0 0 00 00 1 0 8 1 0 00000000
0 0 0 0 0 0 0 00 00 1 1 9 2 0 00000000
0 0 0 0 0 0 0 00 00 1 2 a 8 0 00000000
1 1 1 0 6 2 8 17 15 0 0 0 0 0 00000000 // ids wrap
1 1 7 0 1 5 9 18 16 0 0 0 0 0 00000000
2 3 1 00001234 0 0 0 00 00 0 0 0 0 0 00000000
0 0 0 0 0 0 0 00 00 1 3 b 3 1 00001234 // flush
1 1 2 0 1 4 4 00 00 0 0 0 0 0 00000000
1 1 4 0 2 7 5 14 00 0 0 0 0 0 00000000
2 4 0 00000000 0 0 0 00 00 0 0 0 0 0 00000000
2 5 0 00000000 0 0 0 00 00 1 4 1 9 0 00000000
0 0 0 0 0 0 0 00 00 1 5 2 4 0 00000000
0 0 0 0 0 0 0 00 00 0 0 0 0 0 00000000

//--- tb/tb_rob_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module tb_rob_top;

   localparam int          CLK_PERIOD = 40;
   localparam int          DRV_DLY    = 2;
   localparam int          FIELDS     = 15;   // Words per command line
   localparam int          MAX_LINES  = 64;
   localparam logic [31:0] CMD_DISP   = 32'd1;
   localparam logic [31:0] CMD_CMPL   = 32'd2;

   logic                                 clk;
   logic                                 rst_n;
   logic                                 disp_valid;
   rob_pkg::dispatch_t                   disp;
   logic                                 cmpl_valid;
   rob_pkg::complete_t                   cmpl;
   rob_pkg::rob_id_t                     disp_robid;
   rob_pkg::src_dep_t [`NUM_SOURCES-1:0] src_dep;
   logic                                 disp_stall;
   logic                                 retire_valid;
   rob_pkg::retire_t                     retire;
   logic                                 flush_valid;
   rob_pkg::paddr_t                      flush_tgt;

   logic [31:0] stim_mem [MAX_LINES*FIELDS];
   int          num_lines;
   int          cycle_cnt = 0;
   int          cycle_limit = 1000;
   int          check_cnt;
   int          err_cnt;
   int          occupancy;   // Entries in flight, per the expected retires
   rob_pkg::uop_t sent_uop [2*`ROB_NUM_ENTS];   // Driven uops by expected id

   rob_top rob_top_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_valid   (disp_valid),
      .disp         (disp),
      .cmpl_valid   (cmpl_valid),
      .cmpl         (cmpl),
      .disp_robid   (disp_robid),
      .src_dep      (src_dep),
      .disp_stall   (disp_stall),
      .retire_valid (retire_valid),
      .retire       (retire),
      .flush_valid  (flush_valid),
      .flush_tgt    (flush_tgt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, the command list did not finish", cycle_cnt);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int step);
      check_cnt++;
      assert (got == exp) else begin
         $display("ERROR %s got %h expected %h at step %0d", name, got, exp, step);
         err_cnt++;
      end
   endtask

   task automatic apply_line(input int step);
      int base;
      base       = step * FIELDS;
      disp_valid = 1'b0;
      cmpl_valid = 1'b0;
      disp       = '0;
      cmpl       = '0;
      if (stim_mem[base] == CMD_DISP) begin
         disp_valid         = 1'b1;
         disp.uop.has_dst   = stim_mem[base+1][0];
         disp.uop.dst       = stim_mem[base+2][`ARCH_REG_W-1:0];
         disp.uop.is_branch = stim_mem[base+3][0];
         disp.src[1]        = stim_mem[base+4][`ARCH_REG_W-1:0];
         disp.src[0]        = stim_mem[base+5][`ARCH_REG_W-1:0];
      end else if (stim_mem[base] == CMD_CMPL) begin
         cmpl_valid   = 1'b1;
         cmpl.robid   = stim_mem[base+1][`ROB_IDX_W:0];
         cmpl.mispred = stim_mem[base+2][0];
         cmpl.tgt     = stim_mem[base+3];
      end
   endtask

   task automatic check_line(input int step);
      int base;
      base = step * FIELDS;
      check_value("disp_stall", 32'(disp_stall), 32'(occupancy == `ROB_NUM_ENTS), step);
      if (stim_mem[base] == CMD_DISP) begin
         check_value("disp_robid", 32'(disp_robid), stim_mem[base+6], step);
         check_value("src_dep[1]", 32'(src_dep[1]), stim_mem[base+7], step);
         check_value("src_dep[0]", 32'(src_dep[0]), stim_mem[base+8], step);
         sent_uop[stim_mem[base+6][`ROB_IDX_W:0]] = disp.uop;
      end
      check_value("retire_valid", 32'(retire_valid), stim_mem[base+9], step);
      if (stim_mem[base+9] != 0) begin
         check_value("retire.robid", 32'(retire.robid), stim_mem[base+10], step);
         check_value("retire.uop", 32'(retire.uop),
                     32'(sent_uop[stim_mem[base+10][`ROB_IDX_W:0]]), step);
         check_value("retire.pdst", 32'(retire.pdst), stim_mem[base+11], step);
         check_value("retire.pdst_old", 32'(retire.pdst_old), stim_mem[base+12], step);
      end
      check_value("flush_valid", 32'(flush_valid), stim_mem[base+13], step);
      if (stim_mem[base+13] != 0)
         check_value("flush_tgt", flush_tgt, stim_mem[base+14], step);
      if (stim_mem[base+13] != 0) begin
         occupancy = 0;   // Flush empties the ROB
      end else begin
         if (stim_mem[base] == CMD_DISP)
            occupancy++;
         if (stim_mem[base+9] != 0)
            occupancy--;
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      disp_valid = 1'b0;
      disp       = '0;
      cmpl_valid = 1'b0;
      cmpl       = '0;
      check_cnt  = 0;
      err_cnt    = 0;
      occupancy  = 0;
      for (int a = 0; a < MAX_LINES*FIELDS; a++)
         stim_mem[a] = 32'hE000_0000 | 32'(a);   // Reads as no valid command
      $readmemh("tb/rob_input.txt", stim_mem);
      num_lines = 0;
      while (num_lines < MAX_LINES && stim_mem[num_lines*FIELDS] <= CMD_CMPL)
         num_lines++;
      cycle_limit = 2 * num_lines + 20;
      if (num_lines == 0) begin
         $display("No command lines were read from tb/rob_input.txt");
         err_cnt++;
      end
      repeat (4) @(posedge clk);
      #DRV_DLY rst_n = 1'b1;
      for (int step = 0; step < num_lines; step++) begin
         @(posedge clk);
         #DRV_DLY;
         apply_line(step);
         #(CLK_PERIOD - 2*DRV_DLY);   // Sample just before the next edge
         check_line(step);
      end
      @(posedge clk);
      #DRV_DLY;
      disp_valid = 1'b0;
      cmpl_valid = 1'b0;
      $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/rob_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rob_top (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  disp_valid,
   input  rob_pkg::dispatch_t                    disp,
   input  logic                                  cmpl_valid,
   input  rob_pkg::complete_t                    cmpl,
   output rob_pkg::rob_id_t                      disp_robid,
   output rob_pkg::src_dep_t [`NUM_SOURCES-1:0]  src_dep,
   output logic                                  disp_stall,
   output logic                                  retire_valid,
   output rob_pkg::retire_t                      retire,
   output logic                                  flush_valid,
   output rob_pkg::paddr_t                       flush_tgt
);

   rob_pkg::rename_t ren;
   logic             rob_full;
   logic             free_empty;

   // Either structure out of room blocks dispatch
   assign disp_stall = rob_full | free_empty;

   rename_map rename_map_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_valid   (disp_valid),
      .disp         (disp),
      .retire_valid (retire_valid),
      .retire       (retire),
      .flush_valid  (flush_valid),
      .ren          (ren),
      .free_empty   (free_empty)
   );

   rob rob_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_valid   (disp_valid),
      .disp_uop     (disp.uop),
      .src_addr     (disp.src),
      .ren          (ren),
      .cmpl_valid   (cmpl_valid),
      .cmpl         (cmpl),
      .disp_robid   (disp_robid),
      .src_dep      (src_dep),
      .rob_full     (rob_full),
      .retire_valid (retire_valid),
      .retire       (retire),
      .flush_valid  (flush_valid),
      .flush_tgt    (flush_tgt)
   );

endmodule

`default_nettype wire

//--- verilog/rename_map.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rename_map (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               disp_valid,
   input  rob_pkg::dispatch_t disp,
   input  logic               retire_valid,
   input  rob_pkg::retire_t   retire,
   input  logic               flush_valid,
   output rob_pkg::rename_t   ren,
   output logic               free_empty
);

   rob_pkg::prf_id_t [`ARCH_REGS-1:0] spec_map;
   rob_pkg::prf_id_t [`ARCH_REGS-1:0] commit_map;
   rob_pkg::prf_id_t [`ARCH_REGS-1:0] commit_nxt;
   logic [`PRF_REGS-1:0]              free_vec;
   logic [`PRF_REGS-1:0]              free_rebuilt;
   rob_pkg::prf_id_t                  free_idx;
   logic                              alloc;
   logic                              ret_free;

   assign alloc      = disp_valid & disp.uop.has_dst;
   assign ret_free   = retire_valid & retire.uop.has_dst;
   assign free_empty = ~|free_vec;

   // Lowest free register
   always_comb begin
      free_idx = '0;
      for (int i = `PRF_REGS-1; i >= 0; i--) begin
         if (free_vec[i])
            free_idx = rob_pkg::prf_id_t'(i);
      end
   end

   assign ren.pdst     = free_idx;
   assign ren.pdst_old = spec_map[disp.uop.dst];

   // Committed map including this cycle's retire
   always_comb begin
      commit_nxt = commit_map;
      if (ret_free)
         commit_nxt[retire.uop.dst] = retire.pdst;
   end

   always_comb begin
      free_rebuilt = '1;
      for (int i = 0; i < `ARCH_REGS; i++) begin
         free_rebuilt[commit_nxt[i]] = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i]   <= rob_pkg::prf_id_t'(i);   // Identity
            commit_map[i] <= rob_pkg::prf_id_t'(i);
         end
         free_vec <= ~`PRF_REGS'((1 << `ARCH_REGS) - 1);
      end else begin
         commit_map <= commit_nxt;
         if (flush_valid) begin
            spec_map <= commit_nxt;
            free_vec <= free_rebuilt;
         end else begin
            if (alloc) begin
               spec_map[disp.uop.dst] <= free_idx;
               free_vec[free_idx]     <= 1'b0;
            end
            if (ret_free)
               free_vec[retire.pdst_old] <= 1'b1;   // Old mapping now dead
         end
      end
   end

   a_no_double_free: assert property (
      @(posedge clk) disable iff (!rst_n)
      ret_free |-> !free_vec[retire.pdst_old]
   ) else $error("rename_map: freeing already free register %h", retire.pdst_old);

endmodule

`default_nettype wire

//--- verilog/rob.sv
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rob (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   disp_valid,
   input  rob_pkg::uop_t                          disp_uop,
   input  rob_pkg::arch_reg_t [`NUM_SOURCES-1:0]  src_addr,
   input  rob_pkg::rename_t                       ren,
   input  logic                                   cmpl_valid,
   input  rob_pkg::complete_t                     cmpl,
   output rob_pkg::rob_id_t                       disp_robid,
   output rob_pkg::src_dep_t [`NUM_SOURCES-1:0]   src_dep,
   output logic                                   rob_full,
   output logic                                   retire_valid,
   output rob_pkg::retire_t                       retire,
   output logic                                   flush_valid,
   output rob_pkg::paddr_t                        flush_tgt
);

   rob_pkg::rob_id_t           head;
   rob_pkg::rob_id_t           tail;
   logic [`ROB_IDX_W-1:0]      head_idx;
   logic [`ROB_IDX_W-1:0]      tail_idx;
   logic [`ROB_NUM_ENTS-1:0]   valid_vec;
   logic [`ROB_NUM_ENTS-1:0]   ready_vec;
   logic [`ROB_NUM_ENTS-1:0]   alloc_oh;
   logic [`ROB_NUM_ENTS-1:0]   cmpl_oh;
   logic [`ROB_NUM_ENTS-1:0]   retire_oh;
   logic                       alloc_en;
   rob_pkg::rob_ent_t          new_ent;
   rob_pkg::rob_ent_t          head_ent;
   rob_pkg::rob_ent_t          ents [`ROB_NUM_ENTS];
   logic [`NUM_SOURCES-1:0][`ROB_NUM_ENTS-1:0] src_match;
   rob_pkg::rob_id_t           occupancy;
   rob_pkg::rob_id_t           cmpl_offset;

   assign head_idx   = head[`ROB_IDX_W-1:0];
   assign tail_idx   = tail[`ROB_IDX_W-1:0];
   assign disp_robid = tail;
   assign rob_full   = (head == {~tail[`ROB_IDX_W], tail_idx});   // Same slot, wrap differs

   // Flush discards a dispatch in the same cycle
   assign alloc_en  = disp_valid & ~flush_valid;
   assign alloc_oh  = alloc_en ? (`ROB_NUM_ENTS'(1) << tail_idx) : '0;
   assign cmpl_oh   = cmpl_valid ? (`ROB_NUM_ENTS'(1) << cmpl.robid[`ROB_IDX_W-1:0]) : '0;
   assign retire_oh = retire_valid ? (`ROB_NUM_ENTS'(1) << head_idx) : '0;

   always_comb begin
      new_ent          = '0;
      new_ent.uop      = disp_uop;
      new_ent.pdst     = ren.pdst;
      new_ent.pdst_old = ren.pdst_old;
   end

   for (genvar i = 0; i < `ROB_NUM_ENTS; i++) begin : g_ent
      rob_entry rob_entry_inst (
         .clk       (clk),
         .rst_n     (rst_n),
         .alloc     (alloc_oh[i]),
         .alloc_ent (new_ent),
         .cmpl_hit  (cmpl_oh[i]),
         .cmpl      (cmpl),
         .retire    (retire_oh[i]),
         .flush     (flush_valid),
         .valid     (valid_vec[i]),
         .ready     (ready_vec[i]),
         .ent       (ents[i])
      );
   end

   // Retire and flush from head
   assign head_ent     = ents[head_idx];
   assign retire_valid = valid_vec[head_idx] & ready_vec[head_idx];
   assign flush_valid  = retire_valid & head_ent.uop.is_branch & head_ent.mispred;
   assign flush_tgt    = head_ent.tgt;

   always_comb begin
      retire.robid    = head;
      retire.uop      = head_ent.uop;
      retire.pdst     = head_ent.pdst;
      retire.pdst_old = head_ent.pdst_old;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head <= '0;
         tail <= '0;
      end else begin
         if (retire_valid)
            head <= head + 1'b1;
         if (flush_valid)
            tail <= head + 1'b1;   // Empty behind the branch
         else if (alloc_en)
            tail <= tail + 1'b1;
      end
   end

   // Producer lookup
   for (genvar s = 0; s < `NUM_SOURCES; s++) begin : g_src
      for (genvar i = 0; i < `ROB_NUM_ENTS; i++) begin : g_match
         assign src_match[s][i] = valid_vec[i] & ents[i].uop.has_dst &
                                  (ents[i].uop.dst == src_addr[s]);
      end
   end

   // Walk from oldest possible slot to youngest, last hit wins
   always_comb begin
      rob_pkg::rob_id_t cand;
      cand = tail;
      for (int s = 0; s < `NUM_SOURCES; s++) begin
         src_dep[s] = '0;
         for (int k = `ROB_NUM_ENTS; k >= 1; k--) begin
            cand = tail - rob_pkg::rob_id_t'(k);   // Keeps the wrap bit right
            if (src_match[s][cand[`ROB_IDX_W-1:0]]) begin
               src_dep[s].pending = 1'b1;
               src_dep[s].robid   = cand;
            end
         end
      end
   end

   assign occupancy   = tail - head;
   assign cmpl_offset = cmpl.robid - head;

   a_no_disp_full: assert property (
      @(posedge clk) disable iff (!rst_n)
      disp_valid |-> !rob_full
   ) else $error("rob: dispatch while full");

   a_cmpl_in_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      cmpl_valid |-> (cmpl_offset < occupancy)
   ) else $error("rob: completion id %h outside occupied range", cmpl.robid);

endmodule

`default_nettype wire

//--- verilog/rob_entry.sv
`timescale 1ns/100ps
`default_nettype none

module rob_entry (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               alloc,
   input  rob_pkg::rob_ent_t  alloc_ent,
   input  logic               cmpl_hit,
   input  rob_pkg::complete_t cmpl,
   input  logic               retire,
   input  logic               flush,
   output logic               valid,
   output logic               ready,
   output rob_pkg::rob_ent_t  ent
);

   // Slot state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= 1'b0;
         ready <= 1'b0;
      end else if (flush || retire) begin
         valid <= 1'b0;
         ready <= 1'b0;
      end else if (alloc) begin
         valid <= 1'b1;
         ready <= 1'b0;   // Waits for its completion
      end else if (cmpl_hit) begin
         ready <= 1'b1;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      if (alloc) begin
         ent <= alloc_ent;
      end else if (cmpl_hit) begin
         ent.mispred <= cmpl.mispred;
         ent.tgt     <= cmpl.tgt;   // Branch target, if any
      end
   end

   // Completion must target a slot that the ROB allocated earlier
   a_cmpl_valid_slot: assert property (
      @(posedge clk) disable iff (!rst_n)
      cmpl_hit |-> valid
   ) else $error("rob_entry: completion hit an invalid slot");

endmodule

`default_nettype wire

//--- verilog/rob_pkg.sv
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

   typedef logic [`ROB_IDX_W:0]    rob_id_t;   // Wrap bit on top of slot index
   typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
   typedef logic [`PRF_ID_W-1:0]   prf_id_t;
   typedef logic [`PADDR_W-1:0]    paddr_t;

   typedef struct packed {
      logic      has_dst;
      arch_reg_t dst;
      logic      is_branch;
   } uop_t;

   typedef struct packed {
      uop_t                              uop;
      arch_reg_t [`NUM_SOURCES-1:0]      src;
   } dispatch_t;

   typedef struct packed {
      prf_id_t pdst;
      prf_id_t pdst_old;   // Mapping displaced by this uop
   } rename_t;

   typedef struct packed {
      rob_id_t robid;
      logic    mispred;
      paddr_t  tgt;
   } complete_t;

   typedef struct packed {
      rob_id_t robid;
      uop_t    uop;
      prf_id_t pdst;
      prf_id_t pdst_old;
   } retire_t;

   // Slot contents
   typedef struct packed {
      uop_t    uop;
      prf_id_t pdst;
      prf_id_t pdst_old;
      logic    mispred;
      paddr_t  tgt;
   } rob_ent_t;

   typedef struct packed {
      logic    pending;
      rob_id_t robid;
   } src_dep_t;

endpackage

`default_nettype wire

//--- include/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// ROB geometry
`define ROB_NUM_ENTS 8
`define ROB_IDX_W    3

// Register files
`define ARCH_REGS    8
`define ARCH_REG_W   3
`define PRF_REGS     16
`define PRF_ID_W     4

`define NUM_SOURCES  2
`define PADDR_W      32

`endif
